// ==== Makefile ====
TOOL    = verilator
FLAGS   = --binary --timing --assert
TOP     = poly_tb
FLIST   = vlog.f
OBJ_DIR = obj_dir
LOG     = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || echo "simulator stopped with an error" >> $(LOG)
	cat $(LOG)
	@if grep -q -e "ERRORS FOUND" -e "simulator stopped" $(LOG); then \
		echo "simulation failed"; exit 1; fi
	@echo "simulation passed"

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== rtl/coef_store.sv ====
// coefficient store
// S memory holds 11 coefficients per slot, N memory one degree per slot
// both have one write port and a registered read port
`timescale 1ns/1ns
`default_nettype none

module coef_store (
	input logic clk,
	input logic rst,
	input poly_pkg::coef_wr_t wr,
	input logic [poly_pkg::s_aw-1:0] s_rd_addr,
	input logic [poly_pkg::slot_w-1:0] n_rd_addr,
	output logic [poly_pkg::word_w-1:0] s_rd_data,
	output logic [poly_pkg::deg_w-1:0] n_rd_data
);

	logic [poly_pkg::word_w-1:0] s_mem [poly_pkg::s_depth];
	logic [poly_pkg::deg_w-1:0] n_mem [poly_pkg::slot_count];

	// S array, plain RAM
	always_ff @(posedge clk)
	begin
		if (wr.s_we)
			s_mem[wr.s_addr] <= wr.coef;
		s_rd_data <= s_mem[s_rd_addr];
	end

	// N array, empty slots read degree 0
	always_ff @(posedge clk or negedge rst)
		if (!rst)
		begin
			for (int i = 0; i < poly_pkg::slot_count; i++)
				n_mem[i] <= '0;
			n_rd_data <= '0;
		end
		else
		begin
			if (wr.n_we)
				n_mem[wr.n_addr] <= wr.deg;
			n_rd_data <= n_mem[n_rd_addr];	// read before write on same slot
		end

endmodule

`default_nettype wire

// ==== rtl/data_buffer.sv ====
// data buffer
// host loaded coefficient memory, registered read port for the STP engine
`timescale 1ns/1ns
`default_nettype none

module data_buffer #(
	parameter int buf_depth = poly_pkg::buf_depth
) (
	input logic clk,
	input logic rst,
	input logic load_valid,
	input logic [$clog2(buf_depth)-1:0] load_addr,
	input logic [poly_pkg::word_w-1:0] load_data,
	input logic rd_en,
	input logic [$clog2(buf_depth)-1:0] rd_addr,
	output logic [poly_pkg::word_w-1:0] rd_data
);

	logic [poly_pkg::word_w-1:0] mem [buf_depth];

	// host write port
	always_ff @(posedge clk)
		if (load_valid)
			mem[load_addr] <= load_data;

	// engine read, holds when idle
	always_ff @(posedge clk or negedge rst)
		if (!rst)
			rd_data <= '0;
		else if (rd_en)
			rd_data <= mem[rd_addr];

endmodule

`default_nettype wire

// ==== rtl/poly_cmd_unit.sv ====
// command unit
// decodes command words, hands STP to the engine, runs RDC read-back
// and forms the single strobed response of every command
`timescale 1ns/1ns
`default_nettype none

module poly_cmd_unit (
	input logic clk,
	input logic rst,
	input logic cmd_valid,
	input poly_pkg::poly_cmd_u cmd,
	output logic stp_start,
	output poly_pkg::stp_req_t stp_req,
	input logic stp_done,
	input logic [31:0] stp_status,
	output logic [poly_pkg::s_aw-1:0] s_rd_addr,
	output logic [poly_pkg::slot_w-1:0] n_rd_addr,
	input logic [poly_pkg::word_w-1:0] s_rd_data,
	input logic [poly_pkg::deg_w-1:0] n_rd_data,
	output logic busy,
	output logic resp_valid,
	output poly_pkg::poly_resp_t resp
);

	typedef enum logic [1:0] {
		cu_idle,
		cu_stp_wait,	// engine running
		cu_rdc_read	// store data arriving
	} cu_state_t;

	cu_state_t state;
	logic accept;
	logic idx_bad;		// latched with the rdc
	logic fire;
	poly_pkg::poly_resp_t resp_next;

	assign accept = cmd_valid && (state == cu_idle);	// drop while busy
	assign busy = (state != cu_idle);

	// stp view
	assign stp_start = accept && (cmd.stp.op == poly_pkg::op_stp);
	assign stp_req.slot = cmd.stp.slot;
	assign stp_req.deg = cmd.stp.deg;

	// rdc view, store read launched in the command cycle
	assign s_rd_addr = (poly_pkg::s_aw)'(cmd.rdc.slot) * (poly_pkg::s_aw)'(poly_pkg::slot_len)
		+ (poly_pkg::s_aw)'(cmd.rdc.idx);
	assign n_rd_addr = cmd.rdc.slot;

	// response forming
	always_comb
	begin
		fire = 1'b0;
		resp_next = '0;
		case (state)
			cu_idle:
				if (accept && cmd.stp.op != poly_pkg::op_stp && cmd.stp.op != poly_pkg::op_rdc)
				begin
					fire = 1'b1;
					resp_next.status = poly_pkg::status_bad_op;
				end
			cu_stp_wait:
				if (stp_done)
				begin
					fire = 1'b1;
					resp_next.result = (stp_status == poly_pkg::status_ok) ? 32'd1 : 32'd0;
					resp_next.status = stp_status;
				end
			cu_rdc_read:
			begin
				fire = 1'b1;
				if (idx_bad)
					resp_next.status = poly_pkg::status_bad_idx;
				else
					resp_next.result = {11'd0, n_rd_data, s_rd_data};	// degree 20:16
			end
			default: ;
		endcase
	end

	always_ff @(posedge clk or negedge rst)
		if (!rst)
		begin
			state <= cu_idle;
			resp_valid <= 1'b0;
			idx_bad <= 1'b0;
		end
		else
		begin
			resp_valid <= fire;	// single cycle strobe
			case (state)
				cu_idle:
					if (accept && cmd.stp.op == poly_pkg::op_stp)
						state <= cu_stp_wait;
					else if (accept && cmd.rdc.op == poly_pkg::op_rdc)
					begin
						state <= cu_rdc_read;
						idx_bad <= (cmd.rdc.idx > poly_pkg::max_deg);
					end
				cu_stp_wait:
					if (stp_done)
						state <= cu_idle;
				default:
					state <= cu_idle;
			endcase
		end

	// payload only
	always_ff @(posedge clk)
		if (fire)
			resp <= resp_next;

endmodule

`default_nettype wire

// ==== rtl/poly_pkg.sv ====
// polynomial coefficient coprocessor, shared definitions
// store geometry, opcodes, status codes and the command/response layouts
`default_nettype none

package poly_pkg;

	// coefficient and buffer sizes
	localparam int word_w = 16;
	localparam int buf_depth = 1024;
	localparam int buf_aw = $clog2(buf_depth);
	localparam int slot_count = 8;
	localparam int slot_w = $clog2(slot_count);	// 3 bit slot field
	localparam int slot_len = 11;			// words per slot
	localparam int s_depth = slot_count * slot_len;	// 88
	localparam int s_aw = $clog2(s_depth);
	localparam int deg_w = 5;
	localparam int idx_w = 4;
	localparam int max_deg = 10;

	// opcodes, 0 and 3 are illegal
	typedef enum logic [1:0] {
		op_stp = 2'd1,
		op_rdc = 2'd2
	} op_t;

	// status words
	localparam logic [31:0] status_ok = 32'd0;
	localparam logic [31:0] status_bad_deg = 32'd1;
	localparam logic [31:0] status_bad_op = 32'd2;
	localparam logic [31:0] status_bad_idx = 32'd3;

	// command word, opcode always in the top two bits
	typedef struct packed {
		op_t op;
		logic [slot_w-1:0] slot;
		logic [deg_w-1:0] deg;
		logic [21:0] unused;
	} stp_view_t;

	typedef struct packed {
		op_t op;
		logic [slot_w-1:0] slot;
		logic [idx_w-1:0] idx;
		logic [22:0] unused;
	} rdc_view_t;

	typedef union packed {
		stp_view_t stp;
		rdc_view_t rdc;
	} poly_cmd_u;

	typedef struct packed {
		logic [31:0] result;
		logic [31:0] status;
	} poly_resp_t;

	typedef struct packed {
		logic [slot_w-1:0] slot;
		logic [deg_w-1:0] deg;
	} stp_req_t;

	// engine side write ports of S and N
	typedef struct packed {
		logic s_we;
		logic [s_aw-1:0] s_addr;
		logic [word_w-1:0] coef;
		logic n_we;
		logic [slot_w-1:0] n_addr;
		logic [deg_w-1:0] deg;
	} coef_wr_t;

endpackage

`default_nettype wire

// ==== rtl/poly_top.sv ====
// polynomial coefficient coprocessor top
// data buffer, coefficient store, STP engine and command unit
`timescale 1ns/1ns
`default_nettype none

module poly_top #(
	parameter int buf_depth = poly_pkg::buf_depth
) (
	input logic clk,
	input logic rst,
	input logic load_valid,
	input logic [$clog2(buf_depth)-1:0] load_addr,
	input logic [poly_pkg::word_w-1:0] load_data,
	input logic cmd_valid,
	input poly_pkg::poly_cmd_u cmd,
	output logic busy,
	output logic resp_valid,
	output poly_pkg::poly_resp_t resp
);

	logic stp_start;
	poly_pkg::stp_req_t stp_req;
	logic stp_done;
	logic [31:0] stp_status;
	logic buf_rd_en;
	logic [$clog2(buf_depth)-1:0] buf_rd_addr;
	logic [poly_pkg::word_w-1:0] buf_rd_data;
	poly_pkg::coef_wr_t coef_wr;
	logic [poly_pkg::s_aw-1:0] s_rd_addr;
	logic [poly_pkg::slot_w-1:0] n_rd_addr;
	logic [poly_pkg::word_w-1:0] s_rd_data;
	logic [poly_pkg::deg_w-1:0] n_rd_data;

	data_buffer #(
		.buf_depth(buf_depth)
	) buf0 (
		.clk(clk),
		.rst(rst),
		.load_valid(load_valid),
		.load_addr(load_addr),
		.load_data(load_data),
		.rd_en(buf_rd_en),
		.rd_addr(buf_rd_addr),
		.rd_data(buf_rd_data)
	);

	coef_store store0 (
		.clk(clk),
		.rst(rst),
		.wr(coef_wr),
		.s_rd_addr(s_rd_addr),
		.n_rd_addr(n_rd_addr),
		.s_rd_data(s_rd_data),
		.n_rd_data(n_rd_data)
	);

	stp_engine #(
		.buf_depth(buf_depth)
	) eng0 (
		.clk(clk),
		.rst(rst),
		.start(stp_start),
		.req(stp_req),
		.done(stp_done),
		.status(stp_status),
		.buf_rd_en(buf_rd_en),
		.buf_rd_addr(buf_rd_addr),
		.buf_rd_data(buf_rd_data),
		.coef_wr(coef_wr)
	);

	poly_cmd_unit cmd0 (
		.clk(clk),
		.rst(rst),
		.cmd_valid(cmd_valid),
		.cmd(cmd),
		.stp_start(stp_start),
		.stp_req(stp_req),
		.stp_done(stp_done),
		.stp_status(stp_status),
		.s_rd_addr(s_rd_addr),
		.n_rd_addr(n_rd_addr),
		.s_rd_data(s_rd_data),
		.n_rd_data(n_rd_data),
		.busy(busy),
		.resp_valid(resp_valid),
		.resp(resp)
	);

endmodule

`default_nettype wire

// ==== rtl/stp_engine.sv ====
// STP engine
// runs one store-polynomial: validates the degree, streams N+1 words from the
// data buffer at a persistent read pointer into slot A of S, records N in N
// reads are pipelined, word i is written while word i+1 is fetched
`timescale 1ns/1ns
`default_nettype none

module stp_engine #(
	parameter int buf_depth = poly_pkg::buf_depth
) (
	input logic clk,
	input logic rst,
	input logic start,
	input poly_pkg::stp_req_t req,
	output logic done,
	output logic [31:0] status,
	output logic buf_rd_en,
	output logic [$clog2(buf_depth)-1:0] buf_rd_addr,
	input logic [poly_pkg::word_w-1:0] buf_rd_data,
	output poly_pkg::coef_wr_t coef_wr
);

	typedef enum logic [2:0] {
		st_idle,
		st_check,	// degree validation
		st_fetch,	// first read, degree write
		st_write,	// write word cnt, read next
		st_error,
		st_finish	// last word, done
	} state_t;

	state_t state;
	logic [$clog2(buf_depth)-1:0] ptr;	// survives between commands
	logic [poly_pkg::slot_w-1:0] slot_q;
	logic [poly_pkg::deg_w-1:0] deg_q;
	logic [poly_pkg::idx_w-1:0] cnt;	// word being written
	logic [poly_pkg::s_aw-1:0] base;	// slot*11
	logic last;				// final write state

	assign base = (poly_pkg::s_aw)'(slot_q) * (poly_pkg::s_aw)'(poly_pkg::slot_len);
	assign last = ((poly_pkg::deg_w)'(cnt) + 1'b1) == deg_q;

	// control
	always_ff @(posedge clk or negedge rst)
		if (!rst)
		begin
			state <= st_idle;
			ptr <= '0;
			cnt <= '0;
		end
		else
		begin
			if (buf_rd_en)
				ptr <= ptr + 1'b1;	// one step per word consumed
			case (state)
				st_idle:
					if (start)
					begin
						state <= st_check;
						cnt <= '0;
					end
				st_check:
					state <= (deg_q > poly_pkg::max_deg) ? st_error : st_fetch;
				st_fetch:
					state <= (deg_q == '0) ? st_finish : st_write;	// degree 0, one word
				st_write:
				begin
					cnt <= cnt + 1'b1;
					if (last)
						state <= st_finish;
				end
				default:
					state <= st_idle;	// error, finish
			endcase
		end

	// request capture
	always_ff @(posedge clk)
		if (state == st_idle && start)
		begin
			slot_q <= req.slot;
			deg_q <= req.deg;
		end

	// buffer side
	assign buf_rd_en = (state == st_fetch) || (state == st_write);
	assign buf_rd_addr = ptr;

	// handshake back to the command unit
	assign done = (state == st_finish) || (state == st_error);
	assign status = (state == st_error) ? poly_pkg::status_bad_deg : poly_pkg::status_ok;

	// store writes
	always_comb
	begin
		coef_wr.s_we = (state == st_write) || (state == st_finish);
		coef_wr.s_addr = base + (poly_pkg::s_aw)'(cnt);
		coef_wr.coef = buf_rd_data;	// word fetched last cycle
		coef_wr.n_we = (state == st_fetch);	// degree only once valid
		coef_wr.n_addr = slot_q;
		coef_wr.deg = deg_q;
	end

endmodule

`default_nettype wire

// ==== tb/poly_checker.sv ====
// command unit handshake assertions
// response strobe width, busy after an engine start, busy ends with the response
`timescale 1ns/1ns
`default_nettype none

module poly_checker (
	input logic clk,
	input logic rst,
	input logic resp_valid,
	input logic busy,
	input logic stp_start
);

	// one strobe per response, never two cycles
	resp_pulse: assert property (@(posedge clk) disable iff (!rst)
		resp_valid |=> !resp_valid)
		else $error("resp_valid high for more than one cycle");

	// engine start moves the unit out of idle
	start_idle: assert property (@(posedge clk) disable iff (!rst)
		stp_start |=> busy)
		else $error("stp_start did not make the command unit busy");

	busy_end: assert property (@(posedge clk) disable iff (!rst)
		$fell(busy) |-> resp_valid)	// busy drops with the response
		else $error("busy fell without a response");

endmodule

bind poly_cmd_unit poly_checker chk0 (
	.clk(clk),
	.rst(rst),
	.resp_valid(resp_valid),
	.busy(busy),
	.stp_start(stp_start)
);

`default_nettype wire

// ==== tb/poly_clkgen.sv ====
// testbench clock and reset
// 4 ns clock, active low reset held over the first 4 rising edges
`timescale 1ns/1ns
`default_nettype none

module poly_clkgen (
	output logic clk,
	output logic rst
);

	initial
	begin
		clk = 1'b0;
		forever
			#2 clk = ~clk;	// 250 MHz
	end

	initial
	begin
		rst = 1'b0;
		repeat (4) @(posedge clk);
		rst <= 1'b1;	// flops still see reset on this edge
	end

endmodule

`default_nettype wire

// ==== tb/poly_tb.sv ====
// polynomial coprocessor testbench
// loads the data buffer and replays command vectors from the vectors file,
// checking result, status and latency of every response
`timescale 1ns/1ns
`default_nettype none

module poly_tb;

	localparam int rec_words = 5;		// kind plus four words
	localparam int max_recs = 64;
	localparam int resp_timeout = 40;	// cycles per command
	localparam int rst_timeout = 20;

	logic clk;
	logic rst;
	logic load_valid;
	logic [poly_pkg::buf_aw-1:0] load_addr;
	logic [poly_pkg::word_w-1:0] load_data;
	logic cmd_valid;
	poly_pkg::poly_cmd_u cmd;
	logic busy;
	logic resp_valid;
	poly_pkg::poly_resp_t resp;

	logic [31:0] vec [rec_words*max_recs];
	int errors;
	int checks;
	bit timed_out;

	poly_clkgen clk0 (
		.clk(clk),
		.rst(rst)
	);

	poly_top #(
		.buf_depth(poly_pkg::buf_depth)
	) dut0 (
		.clk(clk),
		.rst(rst),
		.load_valid(load_valid),
		.load_addr(load_addr),
		.load_data(load_data),
		.cmd_valid(cmd_valid),
		.cmd(cmd),
		.busy(busy),
		.resp_valid(resp_valid),
		.resp(resp)
	);

	task automatic check_value(input string what, input logic [31:0] got,
		input logic [31:0] exp);
		checks++;
		if (got !== exp)	// X counts as wrong
		begin
			errors++;
			$display("error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
		end
	endtask

	// latency from the timing rules, counted from the sampling edge
	function automatic int expected_latency(input poly_pkg::poly_cmd_u c);
		if (c.stp.op == poly_pkg::op_stp)
		begin
			if (int'(c.stp.deg) > poly_pkg::max_deg)
				return 3;	// start, check, report
			return int'(c.stp.deg) + 4;
		end
		if (c.rdc.op == poly_pkg::op_rdc)
			return 2;
		return 1;		// bad opcode answered at once
	endfunction

	task automatic load_words(input logic [31:0] base, input logic [31:0] d0,
		input logic [31:0] d1, input logic [31:0] d2);
		logic [31:0] data [3];
		data[0] = d0;
		data[1] = d1;
		data[2] = d2;
		for (int i = 0; i < 3; i++)
		begin
			@(posedge clk);
			load_valid <= 1'b1;
			load_addr <= (poly_pkg::buf_aw)'(base + 32'(i));
			load_data <= data[i][poly_pkg::word_w-1:0];
		end
		@(posedge clk);
		load_valid <= 1'b0;
	endtask

	task automatic send_cmd(
		input logic [31:0] word,
		input bit second,		// hold cmd_valid a second cycle
		input logic [31:0] extra,
		output poly_pkg::poly_resp_t got,
		output int cycles,
		output bit seen,
		output logic busy_first,
		output logic busy_resp
	);
		seen = 1'b0;
		got = '0;
		busy_first = 1'b0;
		busy_resp = 1'b0;
		@(posedge clk);
		cmd_valid <= 1'b1;
		cmd <= word;
		@(posedge clk);			// DUT samples the command here
		cycles = 1;
		if (second)
			cmd <= extra;		// lands while busy
		else
			cmd_valid <= 1'b0;
		while (!seen && cycles <= resp_timeout)
		begin
			@(negedge clk);		// outputs settled
			if (cycles == 1)
				busy_first = busy;	// cycle after the command
			if (resp_valid)
			begin
				seen = 1'b1;
				got = resp;
				busy_resp = busy;
			end
			else
			begin
				@(posedge clk);
				cmd_valid <= 1'b0;
				cycles++;
			end
		end
	endtask

	task automatic play_cmd(input logic [31:0] kind, input logic [31:0] word,
		input logic [31:0] exp_result, input logic [31:0] exp_status,
		input logic [31:0] extra);
		poly_pkg::poly_resp_t got;
		int cycles;
		bit seen;
		logic busy_first;
		logic busy_resp;
		send_cmd(word, kind == 32'd3, extra, got, cycles, seen, busy_first, busy_resp);
		if (!seen)
		begin
			$display("timeout, no response to command %h after %0d cycles",
				word, resp_timeout);
			timed_out = 1'b1;
		end
		else
		begin
			check_value($sformatf("result of %h", word), got.result, exp_result);
			check_value($sformatf("status of %h", word), got.status, exp_status);
			check_value($sformatf("latency of %h", word), cycles,
				expected_latency(word));
			// busy only while a response is still pending
			check_value($sformatf("busy after %h", word), 32'(busy_first),
				32'(expected_latency(word) > 1));
			check_value($sformatf("busy at response to %h", word), 32'(busy_resp), 32'd0);
			if (kind == 32'd3)
				repeat (4)		// dropped command must stay silent
				begin
					@(negedge clk);
					check_value("response to dropped command", 32'(resp_valid), 32'd0);
				end
		end
	endtask

	initial
	begin
		int rec;
		int wait_cycles;
		logic [31:0] kind;
		bit running;
		load_valid = 1'b0;
		load_addr = '0;
		load_data = '0;
		cmd_valid = 1'b0;
		cmd = '0;
		errors = 0;
		checks = 0;
		timed_out = 1'b0;
		$readmemh("tb/poly_vectors.txt", vec);

		wait_cycles = 0;
		while (!rst && wait_cycles < rst_timeout)
		begin
			@(posedge clk);
			wait_cycles++;
		end
		if (!rst)
		begin
			$display("reset was never released");
			timed_out = 1'b1;
		end

		rec = 0;
		running = 1'b1;
		while (running && !timed_out && rec < max_recs)
		begin
			kind = vec[rec*rec_words];
			case (kind)
				32'd1:
					load_words(vec[rec*rec_words+1], vec[rec*rec_words+2],
						vec[rec*rec_words+3], vec[rec*rec_words+4]);
				32'd2, 32'd3:
					play_cmd(kind, vec[rec*rec_words+1], vec[rec*rec_words+2],
						vec[rec*rec_words+3], vec[rec*rec_words+4]);
				default:
					running = 1'b0;	// end record
			endcase
			rec++;
		end

		$display("checks %0d, errors %0d, timeouts %0d", checks, errors, int'(timed_out));
		if (errors == 0 && !timed_out && checks > 0)
			$display("NO ERRORS");
		else
			$display("ERRORS FOUND");
		$finish;
	end

endmodule

`default_nettype wire

// ==== tb/poly_vectors.txt ====
// kind word1 word2 word3 word4, kind 1 load: base, three data words
// kind 2 cmd: command, result, status  kind 3: same plus command dropped while busy
00000001 00000000 00001a00 00001a01 00001a02
00000001 00000003 00001a03 00001a04 00001a05
00000001 00000006 00001a06 00001a07 00001a08
00000001 00000009 00001a09 00001a0a 00001a0b
00000001 0000000c 00001a0c 00001a0d 00001a0e
00000001 0000000f 00001a0f 00001a10 00001a11
00000001 00000012 00001a12 00001a13 00001a14
00000001 00000015 00001a15 00001a16 00001a17
00000002 50c00000 00000001 00000000 00000000 // stp slot 2 degree 3
00000002 90000000 00031a00 00000000 00000000
00000002 90800000 00031a01 00000000 00000000
00000002 91000000 00031a02 00000000 00000000
00000002 91800000 00031a03 00000000 00000000
00000002 68800000 00000001 00000000 00000000 // stp slot 5 degree 2
00000002 a8000000 00021a04 00000000 00000000
00000002 a9000000 00021a06 00000000 00000000
00000002 91800000 00031a03 00000000 00000000 // slot 2 unchanged
00000002 5b000000 00000000 00000001 00000000 // degree 12 rejected
00000002 58400000 00000001 00000000 00000000 // stp slot 3 degree 1
00000002 98000000 00011a07 00000000 00000000
00000002 98800000 00011a08 00000000 00000000
00000002 9d800000 00000000 00000003 00000000 // index 11
00000002 c0000000 00000000 00000002 00000000 // opcode 3
00000002 70000000 00000001 00000000 00000000 // stp slot 6 degree 0
00000002 6a800000 00000001 00000000 00000000 // stp slot 5 degree 10
00000002 ad000000 000a1a14 00000000 00000000
00000002 a8000000 000a1a0a 00000000 00000000
00000002 b0000000 00001a09 00000000 00000000 // slot 6 unaffected
00000003 78400000 00000001 00000000 70400000 // stp slot 7, second stp dropped
00000002 b8800000 00011a16 00000000 00000000
00000002 b0000000 00001a09 00000000 00000000
00000000 00000000 00000000 00000000 00000000

// ==== vlog.f ====
rtl/poly_pkg.sv
rtl/data_buffer.sv
rtl/coef_store.sv
rtl/stp_engine.sv
rtl/poly_cmd_unit.sv
rtl/poly_top.sv
tb/poly_clkgen.sv
tb/poly_checker.sv
tb/poly_tb.sv
